/* alu_ctrl.sv */
////////////////////////////////////////
// APB slave of the execution unit
// Stages operands, issues commands, tracks
// pending registers and writes results back
////////////////////////////////////////

`timescale 1ns/1ps
`include "alu_defs.svh"

module alu_ctrl (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [7:0]             paddr,
    input  logic [31:0]            pwdata,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,
    output alu_pkg::issue_t        issue,
    input  alu_pkg::result_t       logic_res,
    input  alu_pkg::result_t       cmp_res,
    input  alu_pkg::result_t       ldr_res,
    input  logic [31:0]            rf_rdata,
    output logic                   rf_we,
    output logic [2:0]             rf_waddr,
    output logic [31:0]            rf_wdata,
    output logic [2:0]             rf_raddr
);
    import alu_pkg::*;

    ctrl_state_e            state;
    logic [`ALU_NREGS-1:0]  pending;
    logic [`ALU_NREGS-1:0]  set_mask;
    logic [`ALU_NREGS-1:0]  clr_mask;
    logic [`ALU_DATA_W-1:0] opa;
    logic [`ALU_DATA_W-1:0] opb;
    logic                   sel_opa, sel_opb, sel_cmd, sel_status, sel_rf;
    logic                   access, rd_wait, err, done, cmd_legal;

    // Address decode, result registers are word aligned from 0x20 to 0x3C
    assign sel_opa    = (paddr == `ALU_ADDR_OPA);
    assign sel_opb    = (paddr == `ALU_ADDR_OPB);
    assign sel_cmd    = (paddr == `ALU_ADDR_CMD);
    assign sel_status = (paddr == `ALU_ADDR_STATUS);
    assign sel_rf     = ((paddr & 8'hE3) == `ALU_ADDR_RF);

    // Command word holds the opcode in bits 3:0 and the destination in bits 6:4
    assign cmd_legal = (pwdata[3:0] != 4'hF);
    assign rf_raddr  = paddr[4:2];

    assign access  = psel && penable && (state != IDLE);
    // A read of a register still in flight stalls until its result lands
    assign rd_wait = !pwrite && sel_rf && pending[paddr[4:2]];
    assign pready  = access && !rd_wait;

    always_comb begin
        if (pwrite)
            err = !(sel_opa || sel_opb || (sel_cmd && cmd_legal));
        else
            err = !(sel_opa || sel_opb || sel_cmd || sel_status || sel_rf);
    end

    assign pslverr = pready && err;
    assign done    = pready && !err;

    always_comb begin
        prdata = '0;
        if (sel_opa)
            prdata = opa;
        else if (sel_opb)
            prdata = opb;
        else if (sel_cmd)
            prdata[6:0] = {issue.dest, issue.op};
        else if (sel_status)
            prdata[`ALU_NREGS-1:0] = pending;
        else if (sel_rf)
            prdata = rf_rdata;
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (psel && !penable) state <= SETUP;
                SETUP:   if (!access || pready) state <= IDLE;
                         else state <= WAIT_RD;
                WAIT_RD: if (pready || !psel) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Operands are latched into the issue word when the command lands
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            opa   <= '0;
            opb   <= '0;
            issue <= '0;
        end else begin
            issue.valid <= 1'b0;
            if (done && pwrite) begin
                if (sel_opa)
                    opa <= pwdata;
                if (sel_opb)
                    opb <= pwdata;
                if (sel_cmd) begin
                    issue.valid <= 1'b1;
                    issue.op    <= alu_op_e'(pwdata[3:0]);
                    issue.dest  <= pwdata[6:4];
                    issue.a     <= opa;
                    issue.b     <= opb;
                end
            end
        end
    end

    // At most one unit presents a valid result in any cycle
    always_comb begin
        rf_we    = 1'b0;
        rf_waddr = '0;
        rf_wdata = '0;
        if (logic_res.valid) begin
            rf_we    = 1'b1;
            rf_waddr = logic_res.dest;
            rf_wdata = logic_res.data;
        end else if (cmp_res.valid) begin
            rf_we    = 1'b1;
            rf_waddr = cmp_res.dest;
            rf_wdata = cmp_res.data;
        end else if (ldr_res.valid) begin
            rf_we    = 1'b1;
            rf_waddr = ldr_res.dest;
            rf_wdata = ldr_res.data;
        end
    end

    always_comb begin
        set_mask = '0;
        clr_mask = '0;
        if (done && pwrite && sel_cmd)
            set_mask[pwdata[6:4]] = 1'b1;
        if (rf_we)
            clr_mask[rf_waddr] = 1'b1;
    end

    // A new issue to a register wins over the retiring write of the same register
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n)
            pending <= '0;
        else
            pending <= (pending & ~clr_mask) | set_mask;
    end

endmodule

/* alu_defs.svh */
////////////////////////////////////////
// Shared widths, pipeline depth and APB
// address map of the scalar execution unit
////////////////////////////////////////

`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

// Operand and result width
`define ALU_DATA_W 32

// Cycles from a valid issue to the register file write
`define ALU_DEPTH 3

// Number of result registers
`define ALU_NREGS 8

// APB byte addresses
`define ALU_ADDR_OPA    8'h00
`define ALU_ADDR_OPB    8'h04
`define ALU_ADDR_CMD    8'h08
`define ALU_ADDR_STATUS 8'h0C

// Base of the result registers, entry i sits at base plus 4*i
`define ALU_ADDR_RF     8'h20

`endif

/* alu_fp_cmp_unit.sv */
////////////////////////////////////////
// Two stage float compare and saturation
// Operands are assumed not to be NaN
////////////////////////////////////////

`timescale 1ns/1ps
`include "alu_defs.svh"

module alu_fp_cmp_unit (
    input  logic             clock,
    input  logic             rst_n,
    input  alu_pkg::issue_t  issue,
    output alu_pkg::result_t res
);
    import alu_pkg::*;

    // Maps a float onto an unsigned key with the same ordering
    function automatic logic [`ALU_DATA_W-1:0] order_key(input logic [`ALU_DATA_W-1:0] x);
        logic [`ALU_DATA_W-1:0] v;
        // Negative zero folds onto positive zero
        v = (x[`ALU_DATA_W-2:0] == '0) ? '0 : x;
        if (v[`ALU_DATA_W-1])
            order_key = ~v;
        else
            order_key = {1'b1, v[`ALU_DATA_W-2:0]};
    endfunction

    logic [`ALU_DATA_W-1:0] key_a;
    logic [`ALU_DATA_W-1:0] key_b;
    logic [`ALU_DATA_W-1:0] data;
    logic                   is_cmp;
    issue_t                 s1;
    logic                   s1_gt;
    logic                   s1_eq;

    assign is_cmp = issue.op inside {FGT, FLE, FEQ, FNE, SATP, SATN};
    assign key_a  = order_key(issue.a);
    assign key_b  = order_key(issue.b);

    // Stage one keeps the operands and the two ordering flags
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            s1    <= '0;
            s1_gt <= 1'b0;
            s1_eq <= 1'b0;
        end else begin
            s1.valid <= issue.valid && is_cmp;
            s1.op    <= issue.op;
            s1.dest  <= issue.dest;
            s1.a     <= issue.a;
            s1.b     <= issue.b;
            s1_gt    <= key_a > key_b;
            s1_eq    <= key_a == key_b;
        end
    end

    always_comb begin
        case (s1.op)
            FGT:     data = `ALU_DATA_W'(s1_gt);
            FLE:     data = `ALU_DATA_W'(!s1_gt);
            FEQ:     data = `ALU_DATA_W'(s1_eq);
            FNE:     data = `ALU_DATA_W'(!s1_eq);
            SATP:    data = s1_gt ? s1.b : s1.a;
            SATN:    data = (!s1_gt && !s1_eq) ? s1.b : s1.a;
            default: data = '0;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            res <= '0;
        end else begin
            res.valid <= s1.valid;
            res.dest  <= s1.dest;
            res.data  <= data;
        end
    end

endmodule

/* alu_logic_unit.sv */
////////////////////////////////////////
// Single stage bitwise logic unit
// Handles LAND to BINV
////////////////////////////////////////

`timescale 1ns/1ps
`include "alu_defs.svh"

module alu_logic_unit (
    input  logic             clock,
    input  logic             rst_n,
    input  alu_pkg::issue_t  issue,
    output alu_pkg::result_t res
);
    import alu_pkg::*;

    logic [`ALU_DATA_W-1:0] data;
    logic [`ALU_DATA_W-1:0] bit_mask;
    logic [5:0]             ones;
    logic                   is_logic;

    assign is_logic = issue.op inside {LAND, LOR, LNOT, POPCNT, ABS, BSET, BCLR, BINV};

    // Single bit selected by the low five bits of B
    assign bit_mask = `ALU_DATA_W'(1) << issue.b[4:0];

    // Count of set bits in A, at most 32 so six bits suffice
    always_comb begin
        ones = '0;
        for (int i = 0; i < `ALU_DATA_W; i++)
            ones = ones + 6'(issue.a[i]);
    end

    always_comb begin
        case (issue.op)
            LAND:    data = issue.a & issue.b;
            LOR:     data = issue.a | issue.b;
            LNOT:    data = ~issue.a;
            POPCNT:  data = `ALU_DATA_W'(ones);
            ABS:     data = {1'b0, issue.a[`ALU_DATA_W-2:0]};
            BSET:    data = issue.a | bit_mask;
            BCLR:    data = issue.a & ~bit_mask;
            BINV:    data = issue.a ^ bit_mask;
            default: data = '0;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            res <= '0;
        end else begin
            res.valid <= issue.valid && is_logic;
            res.dest  <= issue.dest;
            res.data  <= data;
        end
    end

endmodule

/* alu_pkg.sv */
////////////////////////////////////////
// Types shared by the execution unit
// opcodes, APB states, issue and result
////////////////////////////////////////

`include "alu_defs.svh"

package alu_pkg;

    // Opcode 15 is not assigned and is rejected by the controller
    typedef enum logic [3:0] {
        LAND   = 4'd0,
        LOR    = 4'd1,
        LNOT   = 4'd2,
        POPCNT = 4'd3,
        ABS    = 4'd4,
        BSET   = 4'd5,
        BCLR   = 4'd6,
        BINV   = 4'd7,
        FGT    = 4'd8,
        FLE    = 4'd9,
        FEQ    = 4'd10,
        FNE    = 4'd11,
        SATP   = 4'd12,
        SATN   = 4'd13,
        LDR    = 4'd14
    } alu_op_e;

    // APB phase tracking in the controller
    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        WAIT_RD
    } ctrl_state_e;

    // Operation broadcast from the controller to every unit
    typedef struct packed {
        logic                   valid;
        alu_op_e                op;
        logic [2:0]             dest;
        logic [`ALU_DATA_W-1:0] a;
        logic [`ALU_DATA_W-1:0] b;
    } issue_t;

    // Result of one unit, tagged with its destination register
    typedef struct packed {
        logic                   valid;
        logic [2:0]             dest;
        logic [`ALU_DATA_W-1:0] data;
    } result_t;

endpackage

/* alu_props.sv */
////////////////////////////////////////
// Assertions on the APB response and the
// write-back of the execution unit
////////////////////////////////////////

`timescale 1ns/1ps
`include "alu_defs.svh"

module alu_props (
    input logic                  clock,
    input logic                  rst_n,
    input logic                  pready,
    input logic                  pslverr,
    input logic                  rf_we,
    input logic [2:0]            rf_waddr,
    input logic [`ALU_NREGS-1:0] pending,
    input alu_pkg::issue_t       issue
);

    // A retired register is free again unless a new command claimed it on the same edge
    a_pending_cleared : assert property (
        @(posedge clock) disable iff (!rst_n)
        rf_we |=> (!pending[$past(rf_waddr)] ||
                   (issue.valid && (issue.dest == $past(rf_waddr))))
    ) else $error("Pending bit still set after the write-back of its register");

    // An error response belongs to a completing transfer and never issues a command
    a_err_with_ready : assert property (
        @(posedge clock) disable iff (!rst_n)
        pslverr |=> ($past(pready) && !issue.valid)
    ) else $error("pslverr came without pready or its transfer issued a command");

    // APB needs at least two cycles per transfer, so issues never touch
    a_issue_single : assert property (
        @(posedge clock) disable iff (!rst_n)
        issue.valid |=> !issue.valid
    ) else $error("Issue valid is high in two consecutive cycles");

endmodule

/* alu_regfile.sv */
////////////////////////////////////////
// Result register file
// One synchronous write, one async read
////////////////////////////////////////

`timescale 1ns/1ps
`include "alu_defs.svh"

module alu_regfile (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic                   we,
    input  logic [2:0]             waddr,
    input  logic [`ALU_DATA_W-1:0] wdata,
    input  logic [2:0]             raddr,
    output logic [`ALU_DATA_W-1:0] rdata
);

    logic [`ALU_DATA_W-1:0] regs [`ALU_NREGS];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `ALU_NREGS; i++)
                regs[i] <= '0;
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // Read is combinational so a result is visible the cycle after its write
    assign rdata = regs[raddr];

endmodule

/* alu_slice.sv */
////////////////////////////////////////
// Delay line of result structs that
// brings every unit to one latency
////////////////////////////////////////

`timescale 1ns/1ps

module alu_slice #(
    parameter int N_STAGES = 1
) (
    input  logic             clock,
    input  logic             rst_n,
    input  alu_pkg::result_t din,
    output alu_pkg::result_t dout
);
    import alu_pkg::*;

    generate
        if (N_STAGES == 0) begin : g_wire
            assign dout = din;
        end else begin : g_pipe
            result_t stage [N_STAGES];

            always_ff @(posedge clock or negedge rst_n) begin
                if (!rst_n) begin
                    for (int i = 0; i < N_STAGES; i++)
                        stage[i] <= '0;
                end else begin
                    stage[0] <= din;
                    for (int i = 1; i < N_STAGES; i++)
                        stage[i] <= stage[i-1];
                end
            end

            assign dout = stage[N_STAGES-1];
        end
    endgenerate

endmodule

/* alu_top.f */
+incdir+.
alu_pkg.sv
alu_slice.sv
alu_regfile.sv
alu_logic_unit.sv
alu_fp_cmp_unit.sv
alu_ctrl.sv
alu_top.sv
alu_props.sv
tb_alu_top.sv

/* alu_top.sv */
////////////////////////////////////////
// Scalar execution unit top level
// APB controller, units, delay lines and
// the result register file
////////////////////////////////////////

`timescale 1ns/1ps
`include "alu_defs.svh"

module alu_top (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [7:0]             paddr,
    input  logic [`ALU_DATA_W-1:0] pwdata,
    output logic [`ALU_DATA_W-1:0] prdata,
    output logic                   pready,
    output logic                   pslverr
);
    import alu_pkg::*;

    issue_t                 issue;
    result_t                logic_early, logic_res;
    result_t                cmp_early, cmp_res;
    result_t                ldr_in, ldr_res;
    logic                   rf_we;
    logic [2:0]             rf_waddr, rf_raddr;
    logic [`ALU_DATA_W-1:0] rf_wdata, rf_rdata;

    alu_ctrl i_alu_ctrl (
        .clock     (clock),
        .rst_n     (rst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .issue     (issue),
        .logic_res (logic_res),
        .cmp_res   (cmp_res),
        .ldr_res   (ldr_res),
        .rf_rdata  (rf_rdata),
        .rf_we     (rf_we),
        .rf_waddr  (rf_waddr),
        .rf_wdata  (rf_wdata),
        .rf_raddr  (rf_raddr)
    );

    alu_logic_unit i_alu_logic_unit (
        .clock (clock),
        .rst_n (rst_n),
        .issue (issue),
        .res   (logic_early)
    );

    alu_slice #(.N_STAGES(`ALU_DEPTH - 1)) i_logic_slice (
        .clock (clock),
        .rst_n (rst_n),
        .din   (logic_early),
        .dout  (logic_res)
    );

    alu_fp_cmp_unit i_alu_fp_cmp_unit (
        .clock (clock),
        .rst_n (rst_n),
        .issue (issue),
        .res   (cmp_early)
    );

    alu_slice #(.N_STAGES(`ALU_DEPTH - 2)) i_cmp_slice (
        .clock (clock),
        .rst_n (rst_n),
        .din   (cmp_early),
        .dout  (cmp_res)
    );

    // Register load needs no unit, operand A goes straight into its delay line
    always_comb begin
        ldr_in.valid = issue.valid && (issue.op == LDR);
        ldr_in.dest  = issue.dest;
        ldr_in.data  = issue.a;
    end

    alu_slice #(.N_STAGES(`ALU_DEPTH)) i_ldr_slice (
        .clock (clock),
        .rst_n (rst_n),
        .din   (ldr_in),
        .dout  (ldr_res)
    );

    alu_regfile i_alu_regfile (
        .clock (clock),
        .rst_n (rst_n),
        .we    (rf_we),
        .waddr (rf_waddr),
        .wdata (rf_wdata),
        .raddr (rf_raddr),
        .rdata (rf_rdata)
    );

endmodule

/* run.sh */
#!/bin/sh
# Builds the execution unit testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_alu_top -f alu_top.f

out=$(./obj_dir/Vtb_alu_top) || true
echo "$out"

if echo "$out" | grep -qF "TEST RESULT: PASS"; then
    exit 0
fi
exit 1

/* tb_alu_top.sv */
////////////////////////////////////////
// Testbench of the scalar execution unit
// Table driven APB tests with error checks
////////////////////////////////////////

`timescale 1ns/1ps
`include "alu_defs.svh"

module tb_alu_top;
    import alu_pkg::*;

    localparam int TIMEOUT = 100;

    logic        clock;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    integer      seed;
    int          errors;
    int          checks;

    // Stimulus table, one entry per operation
    string       t_name[$];
    alu_op_e     t_op[$];
    logic [31:0] t_a[$];
    logic [31:0] t_b[$];
    logic [2:0]  t_dest[$];
    logic [31:0] t_exp[$];

    alu_top i_alu_top (
        .clock   (clock),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    // The pending mask lives in the controller, so the checker sits there
    bind alu_ctrl alu_props i_alu_props (
        .clock    (clock),
        .rst_n    (rst_n),
        .pready   (pready),
        .pslverr  (pslverr),
        .rf_we    (rf_we),
        .rf_waddr (rf_waddr),
        .pending  (pending),
        .issue    (issue)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            $display("[ERROR] %s: expected 0x%h, actual 0x%h", name, exp, act);
            errors++;
        end
    endtask

    // One APB transfer, outputs are sampled on the falling edge
    task automatic apb_transfer(input logic write, input logic [7:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        rdata  = '0;
        err    = 1'b0;
        @(posedge clock);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clock);
        penable <= 1'b1;
        while (!seen && cycles < TIMEOUT) begin
            @(negedge clock);
            if (pready) begin
                seen  = 1'b1;
                rdata = prdata;
                err   = pslverr;
            end else begin
                cycles++;
            end
        end
        @(posedge clock);
        psel    <= 1'b0;
        penable <= 1'b0;
        if (!seen) begin
            $display("Timeout: no pready within %0d cycles for address 0x%h", TIMEOUT, addr);
            errors++;
        end
    endtask

    task automatic write_ok(input string name, input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        apb_transfer(1'b1, addr, data, rdata, err);
        check_value({name, " pslverr"}, 32'd0, {31'd0, err});
    endtask

    task automatic read_ok(input string name, input logic [7:0] addr, input logic [31:0] exp);
        logic [31:0] rdata;
        logic        err;
        apb_transfer(1'b0, addr, 32'd0, rdata, err);
        check_value({name, " pslverr"}, 32'd0, {31'd0, err});
        check_value(name, exp, rdata);
    endtask

    function automatic logic [7:0] rf_addr(input logic [2:0] idx);
        return `ALU_ADDR_RF + {3'd0, idx, 2'd0};
    endfunction

    // Logic results by their definition, one bit at a time
    function automatic logic [31:0] expected_logic(input alu_op_e op, input logic [31:0] a,
                                                   input logic [31:0] b);
        logic [31:0] r;
        r = a;
        case (op)
            LAND:   r = a & b;
            LOR:    r = a | b;
            LNOT:   r = ~a;
            POPCNT: begin
                r = 32'd0;
                for (int i = 0; i < 32; i++)
                    if (a[i])
                        r = r + 32'd1;
            end
            ABS:    r[31] = 1'b0;
            BSET:   r[b[4:0]] = 1'b1;
            BCLR:   r[b[4:0]] = 1'b0;
            BINV:   r[b[4:0]] = ~a[b[4:0]];
            default: r = 32'd0;
        endcase
        return r;
    endfunction

    task automatic add_case(input string name, input alu_op_e op, input logic [31:0] a,
                            input logic [31:0] b, input logic [2:0] dest,
                            input logic [31:0] exp);
        t_name.push_back(name);
        t_op.push_back(op);
        t_a.push_back(a);
        t_b.push_back(b);
        t_dest.push_back(dest);
        t_exp.push_back(exp);
    endtask

    // Operands, command, then a read that waits for the result
    task automatic run_case(input int idx);
        write_ok({t_name[idx], " opa"}, `ALU_ADDR_OPA, t_a[idx]);
        write_ok({t_name[idx], " opb"}, `ALU_ADDR_OPB, t_b[idx]);
        write_ok({t_name[idx], " cmd"}, `ALU_ADDR_CMD, {25'd0, t_dest[idx], t_op[idx]});
        read_ok(t_name[idx], rf_addr(t_dest[idx]), t_exp[idx]);
    endtask

    initial begin
        alu_op_e     op;
        logic [31:0] a_rnd;
        logic [31:0] b_rnd;
        logic [31:0] data;
        logic        err;
        seed    = 32'h65e1_88cc;
        errors  = 0;
        checks  = 0;
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = 8'd0;
        pwdata  = 32'd0;
        repeat (10) @(posedge clock);
        rst_n <= 1'b1;

        read_ok("status after reset", `ALU_ADDR_STATUS, 32'd0);
        read_ok("r5 after reset", rf_addr(3'd5), 32'd0);

        add_case("land",       LAND,   32'hF0F0_1234, 32'h0FF0_FF00, 3'd0, 32'h00F0_1200);
        add_case("lor",        LOR,    32'hA5A5_0000, 32'h0000_5A5A, 3'd1, 32'hA5A5_5A5A);
        add_case("lnot",       LNOT,   32'h1234_5678, 32'h0000_0000, 3'd2, 32'hEDCB_A987);
        add_case("popcnt",     POPCNT, 32'hFFFF_0001, 32'h0000_0000, 3'd3, 32'd17);
        add_case("popcnt all", POPCNT, 32'hFFFF_FFFF, 32'h0000_0000, 3'd4, 32'd32);
        add_case("abs",        ABS,    32'hC048_0000, 32'h0000_0000, 3'd5, 32'h4048_0000);
        add_case("bset",       BSET,   32'h0000_0100, 32'h0000_0025, 3'd6, 32'h0000_0120);
        add_case("bclr",       BCLR,   32'hFFFF_FFFF, 32'h0000_001F, 3'd7, 32'h7FFF_FFFF);
        add_case("binv",       BINV,   32'h0000_00F0, 32'h0000_0004, 3'd0, 32'h0000_00E0);
        // Floats used: 0.5 3F00_0000, 1.0 3F80_0000, 2.0 4000_0000, and their negatives
        add_case("fgt pos",    FGT,  32'h4000_0000, 32'h3F80_0000, 3'd1, 32'd1);
        add_case("fgt pos lt", FGT,  32'h3F80_0000, 32'h4000_0000, 3'd2, 32'd0);
        add_case("fgt neg",    FGT,  32'hBF80_0000, 32'hC000_0000, 3'd3, 32'd1);
        add_case("fgt mixed",  FGT,  32'hBF80_0000, 32'h3F00_0000, 3'd4, 32'd0);
        add_case("fgt zeros",  FGT,  32'h8000_0000, 32'h0000_0000, 3'd5, 32'd0);
        add_case("fle equal",  FLE,  32'h3F80_0000, 32'h3F80_0000, 3'd6, 32'd1);
        add_case("fle neg",    FLE,  32'hC000_0000, 32'hBF00_0000, 3'd7, 32'd1);
        add_case("fle mixed",  FLE,  32'h3F00_0000, 32'hBF80_0000, 3'd0, 32'd0);
        add_case("feq zeros",  FEQ,  32'h0000_0000, 32'h8000_0000, 3'd1, 32'd1);
        add_case("feq sign",   FEQ,  32'h3F80_0000, 32'hBF80_0000, 3'd2, 32'd0);
        add_case("fne zeros",  FNE,  32'h8000_0000, 32'h0000_0000, 3'd3, 32'd0);
        add_case("fne neg",    FNE,  32'hBF80_0000, 32'hC000_0000, 3'd4, 32'd1);
        add_case("satp high",  SATP, 32'h4000_0000, 32'h3F80_0000, 3'd5, 32'h3F80_0000);
        add_case("satp low",   SATP, 32'h3F00_0000, 32'h3F80_0000, 3'd6, 32'h3F00_0000);
        add_case("satp neg",   SATP, 32'hBF80_0000, 32'hC000_0000, 3'd7, 32'hC000_0000);
        add_case("satn low",   SATN, 32'hC000_0000, 32'hBF80_0000, 3'd0, 32'hBF80_0000);
        add_case("satn high",  SATN, 32'h4000_0000, 32'h3F80_0000, 3'd1, 32'h4000_0000);
        add_case("satn mixed", SATN, 32'hBF80_0000, 32'h3F00_0000, 3'd2, 32'h3F00_0000);
        add_case("ldr",        LDR,  32'hDEAD_BEEF, 32'h0000_0000, 3'd3, 32'hDEAD_BEEF);

        // One random case per logic opcode
        for (int k = 0; k < 8; k++) begin
            op    = alu_op_e'(k);
            a_rnd = $random(seed);
            b_rnd = $random(seed);
            add_case($sformatf("random %s", op.name()), op, a_rnd, b_rnd, 3'(k),
                     expected_logic(op, a_rnd, b_rnd));
        end

        for (int i = 0; i < t_name.size(); i++)
            run_case(i);

        // Two commands in flight, the second one still pending at the STATUS read
        write_ok("overlap opa", `ALU_ADDR_OPA, 32'h0000_0F0F);
        write_ok("overlap opb", `ALU_ADDR_OPB, 32'h0000_00FF);
        write_ok("overlap cmd1", `ALU_ADDR_CMD, {25'd0, 3'd1, LAND});
        write_ok("overlap cmd2", `ALU_ADDR_CMD, {25'd0, 3'd2, LOR});
        apb_transfer(1'b0, `ALU_ADDR_STATUS, 32'd0, data, err);
        check_value("status in flight pslverr", 32'd0, {31'd0, err});
        check_value("status in flight r2 pending", 32'd1, {31'd0, data[2]});
        read_ok("overlap r1", rf_addr(3'd1), 32'h0000_000F);
        read_ok("overlap r2", rf_addr(3'd2), 32'h0000_0FFF);
        read_ok("status after completion", `ALU_ADDR_STATUS, 32'd0);

        // Illegal opcode and unmapped addresses end in an error response
        write_ok("preload opa", `ALU_ADDR_OPA, 32'h1357_9BDF);
        write_ok("preload cmd", `ALU_ADDR_CMD, {25'd0, 3'd3, LDR});
        read_ok("preload r3", rf_addr(3'd3), 32'h1357_9BDF);
        write_ok("changed opa", `ALU_ADDR_OPA, 32'hFFFF_FFFF);
        apb_transfer(1'b1, `ALU_ADDR_CMD, {25'd0, 3'd3, 4'hF}, data, err);
        check_value("illegal opcode pslverr", 32'd1, {31'd0, err});
        read_ok("status after illegal opcode", `ALU_ADDR_STATUS, 32'd0);
        apb_transfer(1'b1, 8'h10, 32'hFFFF_FFFF, data, err);
        check_value("unmapped write pslverr", 32'd1, {31'd0, err});
        apb_transfer(1'b0, 8'h14, 32'd0, data, err);
        check_value("unmapped read pslverr", 32'd1, {31'd0, err});
        apb_transfer(1'b0, 8'h40, 32'd0, data, err);
        check_value("read above register file pslverr", 32'd1, {31'd0, err});
        read_ok("r3 kept", rf_addr(3'd3), 32'h1357_9BDF);

        $display("Errors: %0d in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
